/* verilog.f */
+incdir+verilog
verilog/rv32Pkg.sv
verilog/ctrlIf.sv
verilog/decodeControl.sv
verilog/immGen.sv
verilog/alu.sv
verilog/nextPcUnit.sv
verilog/dataMemory.sv
verilog/writebackReg.sv
verilog/rvExecStage.sv
testbench/execChecker.sv
testbench/tbRvExec.sv

/* run.sh */
#!/bin/sh
# builds the rvExecStage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module tbRvExec -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VtbRvExec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  exit 1
fi
exit 0

/* testbench/tbRvExec.sv */
// Testbench for rvExecStage. Rows go in back to back, one per falling edge.
// The caller's register file is only the rs1Val/rs2Val columns of each row.
// Memory rows depend on order, since stores are seen through later loads.
`timescale 1ns/1ns
`include "rv32_macros.svh"

module tbRvExec;

  typedef struct {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] wb;
    logic        rdW;
    logic [31:0] npc;
    logic        hlt;
  } stimRow_t;

  localparam logic [31:0] pcA  = 32'h100;
  localparam logic [31:0] pcA4 = 32'h104;
  localparam logic [31:0] pcB  = 32'h200;
  localparam logic [31:0] pcB4 = 32'h204;
  localparam int          idleCycles = 4;

  logic        clk;
  logic        arstN;
  logic        inValid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [31:0] rs1Val;
  logic [31:0] rs2Val;
  logic        outValid;
  logic [31:0] wbData;
  logic [4:0]  rd;
  logic        rdWrite;
  logic [31:0] nextPc;
  logic        halt;
  logic [31:0] expWb;
  logic [4:0]  expRd;
  logic        expRdWrite;
  logic [31:0] expNextPc;
  logic        expHalt;
  int          checkCount;
  int          errorCount;
  integer      seed;
  bit          tableReady;
  stimRow_t    rows[$];

  rvExecStage u_rvExecStage (
    .clk(clk), .arstN(arstN), .inValid(inValid), .inst(inst), .pc(pc), .rs1Val(rs1Val),
    .rs2Val(rs2Val), .outValid(outValid), .wbData(wbData), .rd(rd), .rdWrite(rdWrite),
    .nextPc(nextPc), .halt(halt)
  );

  execChecker u_execChecker (
    .clk(clk), .arstN(arstN), .inValid(inValid), .expWb(expWb), .expRd(expRd),
    .expRdWrite(expRdWrite), .expNextPc(expNextPc), .expHalt(expHalt),
    .outValid(outValid), .wbData(wbData), .rd(rd), .rdWrite(rdWrite), .nextPc(nextPc),
    .halt(halt), .checkCount(checkCount), .errorCount(errorCount)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk; // 20 ns period

  // instruction encoders with rs1 = x1 and rs2 = x2
  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rdIdx);
    return {f7, 5'd2, 5'd1, f3, rdIdx, `OPC_OP};
  endfunction

  function automatic logic [31:0] iType(input logic [6:0] opc, input logic [11:0] imm,
                                        input logic [2:0] f3, input logic [4:0] rdIdx);
    return {imm, 5'd1, f3, rdIdx, opc};
  endfunction

  function automatic logic [31:0] sType(input logic [11:0] imm, input logic [2:0] f3);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], `OPC_STORE};
  endfunction

  function automatic logic [31:0] bType(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rdIdx);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rdIdx, `OPC_JAL};
  endfunction

  // RV32I branch conditions by funct3
  function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic addRow(input logic [31:0] i, p, r1, r2, wb, input logic rdW,
                        input logic [31:0] npc, input logic hlt);
    stimRow_t r;
    r.inst = i;
    r.pc   = p;
    r.rs1  = r1;
    r.rs2  = r2;
    r.wb   = wb;
    r.rdW  = rdW;
    r.npc  = npc;
    r.hlt  = hlt;
    rows.push_back(r);
  endtask

  task automatic buildTable();
    logic [31:0] a;
    logic [31:0] b;
    addRow(rType(`FUNCT7_ALT, 3'd0, 5'd5), pcA, 32'd5, 32'd9, 32'hFFFF_FFFC, 1'b1, pcA4, 1'b0);
    addRow(rType(7'h00, 3'd1, 5'd5), pcA, 32'd1, 32'd5, 32'h20, 1'b1, pcA4, 1'b0);
    addRow(rType(7'h00, 3'd2, 5'd5), pcA, 32'hFFFF_FFFF, 32'd1, 32'd1, 1'b1, pcA4, 1'b0);
    addRow(rType(7'h00, 3'd3, 5'd5), pcA, 32'hFFFF_FFFF, 32'd1, 32'd0, 1'b1, pcA4, 1'b0);
    addRow(rType(7'h00, 3'd5, 5'd5), pcA, 32'h8000_0000, 32'd4, 32'h0800_0000, 1'b1, pcA4, 1'b0);
    addRow(rType(`FUNCT7_ALT, 3'd5, 5'd5), pcA, 32'h8000_0000, 32'd4, 32'hF800_0000, 1'b1,
           pcA4, 1'b0);
    addRow(rType(7'h00, 3'd0, 5'd0), pcA, 32'd7, 32'd9, 32'd16, 1'b0, pcA4, 1'b0); // x0
    addRow(iType(`OPC_OPIMM, 12'hFFF, 3'd0, 5'd6), pcA, 32'd100, 32'd0, 32'd99, 1'b1, pcA4, 1'b0);
    addRow(iType(`OPC_OPIMM, 12'hFFF, 3'd2, 5'd6), pcA, 32'd5, 32'd0, 32'd0, 1'b1, pcA4, 1'b0);
    addRow(iType(`OPC_OPIMM, 12'hFFF, 3'd3, 5'd6), pcA, 32'd5, 32'd0, 32'd1, 1'b1, pcA4, 1'b0);
    addRow(iType(`OPC_OPIMM, 12'h003, 3'd1, 5'd6), pcA, 32'd3, 32'd0, 32'd24, 1'b1, pcA4, 1'b0);
    addRow(iType(`OPC_OPIMM, 12'h408, 3'd5, 5'd6), pcA, 32'hF000_0000, 32'd0, 32'hFFF0_0000,
           1'b1, pcA4, 1'b0); // srai by 8
    for (int k = 0; k < 2; k++)
    begin
      a = $random(seed);
      b = $random(seed);
      addRow(rType(7'h00, 3'd0, 5'd7), pcA, a, b, a + b, 1'b1, pcA4, 1'b0);
      addRow(rType(`FUNCT7_ALT, 3'd0, 5'd7), pcA, a, b, a - b, 1'b1, pcA4, 1'b0);
      addRow(rType(7'h00, 3'd4, 5'd7), pcA, a, b, a ^ b, 1'b1, pcA4, 1'b0);
      addRow(rType(7'h00, 3'd6, 5'd7), pcA, a, b, a | b, 1'b1, pcA4, 1'b0);
      addRow(rType(7'h00, 3'd7, 5'd7), pcA, a, b, a & b, 1'b1, pcA4, 1'b0);
      addRow(rType(7'h00, 3'd2, 5'd7), pcA, a, b, {31'b0, $signed(a) < $signed(b)}, 1'b1,
             pcA4, 1'b0);
      addRow(rType(7'h00, 3'd3, 5'd7), pcA, a, b, {31'b0, a < b}, 1'b1, pcA4, 1'b0);
    end
    // three operand pairs give every branch type a taken and a not-taken case
    for (int f = 0; f < 8; f++)
    begin
      if (f == 2 || f == 3)
        continue;
      for (int p = 0; p < 3; p++)
      begin
        a = (p == 0) ? 32'd5 : (p == 1) ? 32'd1 : 32'hFFFF_FFFF;
        b = (p == 0) ? 32'd5 : (p == 1) ? 32'hFFFF_FFFF : 32'd1;
        addRow(bType(13'd32, 3'(f)), pcB, a, b, 32'd0, 1'b0,
               branchTaken(3'(f), a, b) ? pcB + 32'd32 : pcB4, 1'b0);
      end
    end
    addRow(bType(13'h1FF8, 3'd1), pcB, 32'd5, 32'd6, 32'd0, 1'b0, 32'h1F8, 1'b0); // back by 8
    addRow(jType(21'h100, 5'd1), pcB, 32'd0, 32'd0, pcB4, 1'b1, 32'h300, 1'b0);
    addRow(iType(`OPC_JALR, 12'd5, 3'd0, 5'd1), pcB, 32'h1000, 32'd0, pcB4, 1'b1, 32'h1004, 1'b0);
    addRow({20'h12345, 5'd3, `OPC_LUI}, pcB, 32'd0, 32'd0, 32'h1234_5000, 1'b1, pcB4, 1'b0);
    addRow({20'h00001, 5'd3, `OPC_AUIPC}, pcB, 32'd0, 32'd0, 32'h1200, 1'b1, pcB4, 1'b0);
    // stores, then loads of the same lanes
    addRow(sType(12'd0, 3'd2), pcA, 32'h40, 32'h8765_43A1, 32'd0, 1'b0, pcA4, 1'b0);
    addRow(iType(`OPC_LOAD, 12'd0, 3'd2, 5'd4), pcA, 32'h40, 32'd0, 32'h8765_43A1, 1'b1, pcA4, 1'b0);
    addRow(iType(`OPC_LOAD, 12'd2, 3'd1, 5'd4), pcA, 32'h40, 32'd0, 32'hFFFF_8765, 1'b1, pcA4, 1'b0);
    addRow(iType(`OPC_LOAD, 12'd2, 3'd5, 5'd4), pcA, 32'h40, 32'd0, 32'h0000_8765, 1'b1, pcA4, 1'b0);
    addRow(iType(`OPC_LOAD, 12'd0, 3'd0, 5'd4), pcA, 32'h40, 32'd0, 32'hFFFF_FFA1, 1'b1, pcA4, 1'b0);
    addRow(iType(`OPC_LOAD, 12'd0, 3'd4, 5'd4), pcA, 32'h40, 32'd0, 32'h0000_00A1, 1'b1, pcA4, 1'b0);
    addRow(sType(12'd1, 3'd0), pcA, 32'h40, 32'h1234_567F, 32'd0, 1'b0, pcA4, 1'b0);
    addRow(iType(`OPC_LOAD, 12'd0, 3'd2, 5'd4), pcA, 32'h40, 32'd0, 32'h8765_7FA1, 1'b1, pcA4, 1'b0);
    addRow(sType(12'd2, 3'd1), pcA, 32'h48, 32'hABCD_8001, 32'd0, 1'b0, pcA4, 1'b0);
    addRow(iType(`OPC_LOAD, 12'hFF8, 3'd2, 5'd4), pcA, 32'h50, 32'd0, 32'h8001_0000, 1'b1,
           pcA4, 1'b0);
    addRow(iType(`OPC_LOAD, 12'd2, 3'd1, 5'd4), pcA, 32'h48, 32'd0, 32'hFFFF_8001, 1'b1, pcA4, 1'b0);
    addRow(iType(`OPC_LOAD, 12'd3, 3'd0, 5'd4), pcA, 32'h48, 32'd0, 32'hFFFF_FF80, 1'b1, pcA4, 1'b0);
    // misaligned or illegal accesses halt and leave memory alone
    addRow(iType(`OPC_LOAD, 12'd1, 3'd1, 5'd4), pcA, 32'h40, 32'd0, 32'd0, 1'b0, 32'd0, 1'b1);
    addRow(iType(`OPC_LOAD, 12'd2, 3'd2, 5'd4), pcA, 32'h40, 32'd0, 32'd0, 1'b0, 32'd0, 1'b1);
    addRow(sType(12'd2, 3'd2), pcA, 32'h40, 32'hDEAD_BEEF, 32'd0, 1'b0, 32'd0, 1'b1);
    addRow(sType(12'd3, 3'd1), pcA, 32'h40, 32'hDEAD_BEEF, 32'd0, 1'b0, 32'd0, 1'b1);
    addRow(sType(12'd0, 3'd3), pcA, 32'h40, 32'hDEAD_BEEF, 32'd0, 1'b0, 32'd0, 1'b1);
    addRow(iType(`OPC_LOAD, 12'd0, 3'd2, 5'd4), pcA, 32'h40, 32'd0, 32'h8765_7FA1, 1'b1, pcA4, 1'b0);
    // decode, funct7 and target halts
    addRow(32'h0000_007F, pcA, 32'd0, 32'd0, 32'd0, 1'b0, 32'd0, 1'b1);
    addRow(rType(7'h01, 3'd0, 5'd5), pcA, 32'd1, 32'd2, 32'd0, 1'b0, 32'd0, 1'b1);
    addRow(bType(13'd16, 3'd2), pcB, 32'd5, 32'd5, 32'd0, 1'b0, 32'd0, 1'b1);
    addRow(bType(13'd6, 3'd0), pcB, 32'd5, 32'd5, 32'd0, 1'b0, 32'd0, 1'b1); // lands on 0x206
    addRow(jType(21'd2, 5'd1), pcB, 32'd0, 32'd0, 32'd0, 1'b0, 32'd0, 1'b1);
  endtask

  initial
  begin
    seed       = 32'h28c67cb2;
    arstN      = 1'b0;
    inValid    = 1'b0;
    inst       = '0;
    pc         = '0;
    rs1Val     = '0;
    rs2Val     = '0;
    expWb      = '0;
    expRd      = '0;
    expRdWrite = 1'b0;
    expNextPc  = '0;
    expHalt    = 1'b0;
    tableReady = 1'b0;
    buildTable();
    tableReady = 1'b1;
    repeat (16) @(negedge clk);
    arstN = 1'b1;
    repeat (idleCycles) @(negedge clk); // idle cycles with nothing in flight
    for (int i = 0; i < rows.size(); i++)
    begin
      inValid    = 1'b1;
      inst       = rows[i].inst;
      pc         = rows[i].pc;
      rs1Val     = rows[i].rs1;
      rs2Val     = rows[i].rs2;
      expWb      = rows[i].wb;
      expRd      = rows[i].inst[11:7];
      expRdWrite = rows[i].rdW;
      expNextPc  = rows[i].npc;
      expHalt    = rows[i].hlt;
      @(negedge clk);
    end
    inValid = 1'b0;
    wait (checkCount == rows.size());
    repeat (2) @(negedge clk);
    $display("%0d results checked, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  initial
  begin : watchdog
    int limitNs;
    wait (tableReady);
    limitNs = (16 + idleCycles + rows.size() + 20) * 20; // reset, idle, rows, margin
    #(limitNs);
    $display("Timeout after %0d ns, only %0d of %0d results seen", limitNs, checkCount,
             rows.size());
    $display("Something failed");
    $finish;
  end

endmodule

/* testbench/execChecker.sv */
// Compares DUT results with the expected values presented with each instruction.
// Expected values are latched at the edge that samples inValid and compared a cycle on.
// wbData and rd are only checked when a register write is expected, nextPc when no halt.
`timescale 1ns/1ns

module execChecker (
  input  logic        clk,
  input  logic        arstN,
  input  logic        inValid,
  input  logic [31:0] expWb,
  input  logic [4:0]  expRd,
  input  logic        expRdWrite,
  input  logic [31:0] expNextPc,
  input  logic        expHalt,
  input  logic        outValid,
  input  logic [31:0] wbData,
  input  logic [4:0]  rd,
  input  logic        rdWrite,
  input  logic [31:0] nextPc,
  input  logic        halt,
  output int          checkCount,
  output int          errorCount
);

  logic        pending; // a result is due this cycle
  logic [31:0] wantWb;
  logic [4:0]  wantRd;
  logic        wantRdWrite;
  logic [31:0] wantNextPc;
  logic        wantHalt;

  always @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      pending <= 1'b0;
    else
    begin
      pending <= inValid;
      if (inValid)
      begin
        wantWb      <= expWb;
        wantRd      <= expRd;
        wantRdWrite <= expRdWrite;
        wantNextPc  <= expNextPc;
        wantHalt    <= expHalt;
      end
    end
  end

  task automatic reportMismatch(input string what, input logic [31:0] got,
                                input logic [31:0] want);
    errorCount++;
    $display("FAIL %0t ns: result %0d %s is %h, expected %h", $time, checkCount, what, got,
             want);
  endtask

  // outputs only move on rising edges
  always @(negedge clk)
  begin
    if (!arstN)
    begin
      checkCount = 0;
      errorCount = 0;
    end
    else if (pending)
    begin
      if (!outValid)
      begin
        errorCount++;
        $display("Error at %0t ns: no outValid one cycle after instruction %0d", $time,
                 checkCount);
      end
      else
      begin
        if (halt !== wantHalt)
          reportMismatch("halt", 32'(halt), 32'(wantHalt));
        if (rdWrite !== wantRdWrite)
          reportMismatch("rdWrite", 32'(rdWrite), 32'(wantRdWrite));
        if (!wantHalt && nextPc !== wantNextPc)
          reportMismatch("nextPc", nextPc, wantNextPc);
        if (wantRdWrite && wbData !== wantWb)
          reportMismatch("wbData", wbData, wantWb);
        if (wantRdWrite && rd !== wantRd)
          reportMismatch("rd", 32'(rd), 32'(wantRd));
      end
      checkCount++;
    end
    else if (outValid !== 1'b0 || rdWrite !== 1'b0 || halt !== 1'b0)
    begin
      errorCount++;
      $display("Error at %0t ns: outValid, rdWrite or halt active with nothing in flight",
               $time);
    end
  end

endmodule

/* verilog/rvExecStage.sv */
// RV32I execute and memory stage, one result per inValid, one cycle later.
// No back-pressure. Register file and fetch live with the caller.
`timescale 1ns/1ns
`include "rv32_macros.svh"

module rvExecStage (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  inValid,
  input  logic [`XLEN-1:0]      inst,
  input  logic [`XLEN-1:0]      pc,
  input  logic [`XLEN-1:0]      rs1Val,
  input  logic [`XLEN-1:0]      rs2Val,
  output logic                  outValid,
  output logic [`XLEN-1:0]      wbData,
  output logic [`REGADDR_W-1:0] rd,
  output logic                  rdWrite,
  output logic [`XLEN-1:0]      nextPc,
  output logic                  halt
);
  import rv32Pkg::*;

  instWord_t        instWord;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] aluOut;
  logic [`XLEN-1:0] nextPcComb;
  logic [`XLEN-1:0] loadData;
  logic             aluHalt;
  logic             pcHalt;
  logic             memHalt;
  logic             blockWrite;

  ctrlIf ctrlBus ();

  assign instWord   = inst;
  assign blockWrite = aluHalt || pcHalt || ctrlBus.decodeHalt; // no store on any halt

  decodeControl u_decodeControl (.inst(instWord), .ctrl(ctrlBus));

  immGen u_immGen (.inst(instWord), .ctrl(ctrlBus), .imm(imm));

  alu u_alu (
    .ctrl(ctrlBus), .inst(instWord), .pc(pc), .rs1Val(rs1Val), .rs2Val(rs2Val),
    .imm(imm), .aluOut(aluOut), .aluHalt(aluHalt)
  );

  nextPcUnit u_nextPcUnit (
    .ctrl(ctrlBus), .inst(instWord), .pc(pc), .rs1Val(rs1Val), .rs2Val(rs2Val),
    .aluOut(aluOut), .nextPc(nextPcComb), .pcHalt(pcHalt)
  );

  dataMemory u_dataMemory (
    .clk(clk), .arstN(arstN), .ctrl(ctrlBus), .inValid(inValid), .addr(aluOut),
    .storeVal(rs2Val), .blockWrite(blockWrite), .loadData(loadData), .memHalt(memHalt)
  );

  writebackReg u_writebackReg (
    .clk(clk), .arstN(arstN), .ctrl(ctrlBus), .inValid(inValid), .inst(instWord),
    .pc(pc), .aluOut(aluOut), .imm(imm), .loadData(loadData), .nextPcIn(nextPcComb),
    .aluHalt(aluHalt), .pcHalt(pcHalt), .memHalt(memHalt), .outValid(outValid),
    .wbData(wbData), .rd(rd), .rdWrite(rdWrite), .nextPc(nextPc), .halt(halt)
  );

endmodule

/* verilog/writebackReg.sv */
// Writeback select and the single output register.
// Payload only loads on inValid, outValid and halt are cleared otherwise.
`timescale 1ns/1ns
`include "rv32_macros.svh"

module writebackReg (
  input  logic                  clk,
  input  logic                  arstN,
  ctrlIf.wb                     ctrl,
  input  logic                  inValid,
  input  rv32Pkg::instWord_t    inst,
  input  logic [`XLEN-1:0]      pc,
  input  logic [`XLEN-1:0]      aluOut,
  input  logic [`XLEN-1:0]      imm,
  input  logic [`XLEN-1:0]      loadData,
  input  logic [`XLEN-1:0]      nextPcIn,
  input  logic                  aluHalt,
  input  logic                  pcHalt,
  input  logic                  memHalt,
  output logic                  outValid,
  output logic [`XLEN-1:0]      wbData,
  output logic [`REGADDR_W-1:0] rd,
  output logic                  rdWrite,
  output logic [`XLEN-1:0]      nextPc,
  output logic                  halt
);
  import rv32Pkg::*;

  logic [`XLEN-1:0] wbValue;
  logic             anyHalt;

  assign anyHalt = ctrl.decodeHalt || aluHalt || pcHalt || memHalt;

  always_comb
  begin
    case (ctrl.wbSel)
      WB_MEM:  wbValue = loadData;
      WB_PC4:  wbValue = pc + 32'd4; // link address
      WB_IMM:  wbValue = imm;
      default: wbValue = aluOut;
    endcase
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      outValid <= 1'b0;
      rdWrite  <= 1'b0;
      halt     <= 1'b0;
    end
    else
    begin
      outValid <= inValid;
      rdWrite  <= inValid && ctrl.regWrite && !anyHalt && (inst.rFmt.rd != '0); // x0 stays 0
      halt     <= inValid && anyHalt;
    end
  end

  always_ff @(posedge clk)
  begin
    if (inValid)
    begin
      wbData <= wbValue;
      rd     <= inst.rFmt.rd;
      nextPc <= nextPcIn;
    end
  end

endmodule

/* verilog/dataMemory.sv */
// 64-word data memory, byte lanes little-endian. Address bits above
// the word index are ignored, so accesses wrap. Cleared on reset.
`timescale 1ns/1ns
`include "rv32_macros.svh"

module dataMemory (
  input  logic             clk,
  input  logic             arstN,
  ctrlIf.mem               ctrl,
  input  logic             inValid,
  input  logic [`XLEN-1:0] addr,
  input  logic [`XLEN-1:0] storeVal,
  input  logic             blockWrite,
  output logic [`XLEN-1:0] loadData,
  output logic             memHalt
);
  import rv32Pkg::*;

  logic [`XLEN-1:0]  mem [`MEM_WORDS];
  logic [`MEM_AW-1:0] wordIdx;
  logic [3:0]         byteEn;
  logic [`XLEN-1:0]   wrData;
  logic [`XLEN-1:0]   laneWord;
  logic               misaligned;
  logic               doWrite;

  assign wordIdx    = addr[`MEM_AW+1:2];
  assign misaligned = (ctrl.memSize == MEM_HALF && addr[0])
                   || (ctrl.memSize == MEM_WORD && addr[1:0] != 2'b00);
  assign memHalt    = (ctrl.memRead || ctrl.memWrite) && misaligned;
  assign doWrite    = inValid && ctrl.memWrite && !memHalt && !blockWrite;

  always_comb
  begin
    case (ctrl.memSize)
      MEM_BYTE:
      begin
        byteEn = 4'b0001 << addr[1:0];
        wrData = {4{storeVal[7:0]}}; // replicated to every lane
      end
      MEM_HALF:
      begin
        byteEn = 4'b0011 << addr[1:0];
        wrData = {2{storeVal[15:0]}};
      end
      default:
      begin
        byteEn = 4'b1111;
        wrData = storeVal;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int w = 0; w < `MEM_WORDS; w++)
        mem[w] <= '0;
    end
    else if (doWrite)
    begin
      for (int b = 0; b < 4; b++)
        if (byteEn[b])
          mem[wordIdx][b*8 +: 8] <= wrData[b*8 +: 8];
    end
  end

  assign laneWord = mem[wordIdx] >> {addr[1:0], 3'b000}; // addressed lane to bit 0

  always_comb
  begin
    case (ctrl.memSize)
      MEM_BYTE:
        loadData = (ctrl.loadExt == LOAD_UNSIGNED) ? {24'b0, laneWord[7:0]}
                                                   : {{24{laneWord[7]}}, laneWord[7:0]};
      MEM_HALF:
        loadData = (ctrl.loadExt == LOAD_UNSIGNED) ? {16'b0, laneWord[15:0]}
                                                   : {{16{laneWord[15]}}, laneWord[15:0]};
      default:
        loadData = laneWord;
    endcase
  end

endmodule

/* verilog/nextPcUnit.sv */
// Branch resolution and next pc. Targets come from the ALU (pc+imm or rs1+imm).
// A taken target off a word boundary halts.
`timescale 1ns/1ns
`include "rv32_macros.svh"

module nextPcUnit (
  ctrlIf.pcu                 ctrl,
  input  rv32Pkg::instWord_t inst,
  input  logic [`XLEN-1:0]   pc,
  input  logic [`XLEN-1:0]   rs1Val,
  input  logic [`XLEN-1:0]   rs2Val,
  input  logic [`XLEN-1:0]   aluOut,
  output logic [`XLEN-1:0]   nextPc,
  output logic               pcHalt
);
  import rv32Pkg::*;

  logic             cond;
  logic             badFunct3;
  logic             taken;
  logic [`XLEN-1:0] target;

  always_comb
  begin
    badFunct3 = 1'b0;
    case (inst.bFmt.funct3)
      3'b000:  cond = (rs1Val == rs2Val);
      3'b001:  cond = (rs1Val != rs2Val);
      3'b100:  cond = ($signed(rs1Val) < $signed(rs2Val));
      3'b101:  cond = ($signed(rs1Val) >= $signed(rs2Val));
      3'b110:  cond = (rs1Val < rs2Val);
      3'b111:  cond = (rs1Val >= rs2Val);
      default:
      begin
        cond      = 1'b0;
        badFunct3 = 1'b1;
      end
    endcase
  end

  assign taken  = ctrl.isJump || (ctrl.isBranch && cond);
  assign target = (inst.iFmt.opcode == `OPC_JALR) ? {aluOut[`XLEN-1:1], 1'b0} : aluOut;
  assign nextPc = taken ? target : pc + 32'd4;
  assign pcHalt = (ctrl.isBranch && badFunct3) || (taken && target[1:0] != 2'b00);

endmodule

/* verilog/alu.sv */
// Integer ALU. Full function decode only for OP and OP-IMM,
// every other opcode just adds its selected operands.
`timescale 1ns/1ns
`include "rv32_macros.svh"

module alu (
  ctrlIf.alu                 ctrl,
  input  rv32Pkg::instWord_t inst,
  input  logic [`XLEN-1:0]   pc,
  input  logic [`XLEN-1:0]   rs1Val,
  input  logic [`XLEN-1:0]   rs2Val,
  input  logic [`XLEN-1:0]   imm,
  output logic [`XLEN-1:0]   aluOut,
  output logic               aluHalt
);
  import rv32Pkg::*;

  logic [`XLEN-1:0] opA;
  logic [`XLEN-1:0] opB;
  logic [`XLEN-1:0] sraOut;
  logic             isOp;
  logic             isOpImm;
  logic             isAlt;
  logic             funct7Bad;
  logic             isShift;

  assign opA       = ctrl.aluSrcA ? pc : rs1Val;
  assign opB       = ctrl.aluSrcB ? imm : rs2Val;
  assign sraOut    = $signed(opA) >>> opB[4:0]; // sign-filling shift
  assign isOp      = (inst.rFmt.opcode == `OPC_OP);
  assign isOpImm   = (inst.rFmt.opcode == `OPC_OPIMM);
  assign isAlt     = (inst.rFmt.funct7 == `FUNCT7_ALT); // imm[11:5] for OP-IMM
  assign funct7Bad = (inst.rFmt.funct7 != 7'b0) && !isAlt;
  assign isShift   = (inst.rFmt.funct3 == 3'b001) || (inst.rFmt.funct3 == 3'b101);
  // OP-IMM only carries funct7 in its shifts
  assign aluHalt   = funct7Bad && (isOp || (isOpImm && isShift));

  always_comb
  begin
    aluOut = opA + opB; // address and link arithmetic
    if (isOp || isOpImm)
    begin
      case (inst.rFmt.funct3)
        3'b000:  aluOut = (isOp && isAlt) ? opA - opB : opA + opB;
        3'b001:  aluOut = opA << opB[4:0];
        3'b010:  aluOut = {31'b0, $signed(opA) < $signed(opB)};
        3'b011:  aluOut = {31'b0, opA < opB};
        3'b100:  aluOut = opA ^ opB;
        3'b101:  aluOut = isAlt ? sraOut : opA >> opB[4:0];
        3'b110:  aluOut = opA | opB;
        default: aluOut = opA & opB;
      endcase
    end
  end

endmodule

/* verilog/immGen.sv */
// Immediate builder. All formats sign-extend from inst bit 31
// except the shift amount, which is zero-extended.
`timescale 1ns/1ns
`include "rv32_macros.svh"

module immGen (
  input  rv32Pkg::instWord_t inst,
  ctrlIf.alu                 ctrl,
  output logic [`XLEN-1:0]   imm
);
  import rv32Pkg::*;

  always_comb
  begin
    case (ctrl.immSel)
      IMM_I:
        imm = {{20{inst.iFmt.imm11_0[11]}}, inst.iFmt.imm11_0};
      IMM_S:
        imm = {{20{inst.sFmt.imm11_5[6]}}, inst.sFmt.imm11_5, inst.sFmt.imm4_0};
      IMM_B:
        imm = {{20{inst.bFmt.imm12}}, inst.bFmt.imm11, inst.bFmt.imm10_5,
               inst.bFmt.imm4_1, 1'b0}; // halfword offsets
      IMM_U:
        imm = {inst.uFmt.imm31_12, 12'b0};
      IMM_J:
        imm = {{12{inst.jFmt.imm20}}, inst.jFmt.imm19_12, inst.jFmt.imm11,
               inst.jFmt.imm10_1, 1'b0};
      IMM_SHAMT:
        imm = {27'b0, inst.rFmt.rs2}; // shamt sits in the rs2 field
      default:
        imm = '0;
    endcase
  end

endmodule

/* verilog/decodeControl.sv */
// Opcode and funct3 decode into the control bundle.
// funct7 legality is left to the ALU, branch funct3 is checked here and in nextPcUnit.
`timescale 1ns/1ns
`include "rv32_macros.svh"

module decodeControl (
  input rv32Pkg::instWord_t inst,
  ctrlIf.dec                ctrl
);
  import rv32Pkg::*;

  logic [2:0] funct3;

  assign funct3 = inst.rFmt.funct3;

  always_comb
  begin
    ctrl.isBranch   = 1'b0;
    ctrl.isJump     = 1'b0;
    ctrl.aluSrcA    = 1'b0;
    ctrl.aluSrcB    = 1'b0;
    ctrl.immSel     = IMM_NONE;
    ctrl.memRead    = 1'b0;
    ctrl.memWrite   = 1'b0;
    ctrl.memSize    = MEM_WORD;
    ctrl.loadExt    = funct3[2] ? LOAD_UNSIGNED : LOAD_SIGNED; // lbu/lhu have bit 2 set
    ctrl.regWrite   = 1'b0;
    ctrl.wbSel      = WB_ALU;
    ctrl.decodeHalt = 1'b0;
    case (inst.rFmt.opcode)
      `OPC_OP:
        ctrl.regWrite = 1'b1;
      `OPC_OPIMM:
      begin
        ctrl.aluSrcB  = 1'b1;
        ctrl.immSel   = (funct3 == 3'b001 || funct3 == 3'b101) ? IMM_SHAMT : IMM_I;
        ctrl.regWrite = 1'b1;
      end
      `OPC_LOAD:
      begin
        ctrl.aluSrcB  = 1'b1;
        ctrl.immSel   = IMM_I;
        ctrl.memRead  = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = WB_MEM;
        case (funct3)
          3'b000, 3'b100: ctrl.memSize = MEM_BYTE;
          3'b001, 3'b101: ctrl.memSize = MEM_HALF;
          3'b010:         ctrl.memSize = MEM_WORD;
          default:        ctrl.decodeHalt = 1'b1; // no such load
        endcase
      end
      `OPC_STORE:
      begin
        ctrl.aluSrcB  = 1'b1;
        ctrl.immSel   = IMM_S;
        ctrl.memWrite = 1'b1;
        case (funct3)
          3'b000:  ctrl.memSize = MEM_BYTE;
          3'b001:  ctrl.memSize = MEM_HALF;
          3'b010:  ctrl.memSize = MEM_WORD;
          default: ctrl.decodeHalt = 1'b1;
        endcase
      end
      `OPC_BRANCH:
      begin
        ctrl.isBranch   = 1'b1;
        ctrl.aluSrcA    = 1'b1; // target is pc + imm
        ctrl.aluSrcB    = 1'b1;
        ctrl.immSel     = IMM_B;
        ctrl.decodeHalt = (funct3 == 3'b010 || funct3 == 3'b011);
      end
      `OPC_JAL:
      begin
        ctrl.isJump   = 1'b1;
        ctrl.aluSrcA  = 1'b1;
        ctrl.aluSrcB  = 1'b1;
        ctrl.immSel   = IMM_J;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = WB_PC4;
      end
      `OPC_JALR:
      begin
        ctrl.isJump   = 1'b1;
        ctrl.aluSrcB  = 1'b1; // rs1 + imm
        ctrl.immSel   = IMM_I;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = WB_PC4;
      end
      `OPC_LUI:
      begin
        ctrl.immSel   = IMM_U;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = WB_IMM;
      end
      `OPC_AUIPC:
      begin
        ctrl.aluSrcA  = 1'b1;
        ctrl.aluSrcB  = 1'b1;
        ctrl.immSel   = IMM_U;
        ctrl.regWrite = 1'b1;
      end
      default:
        ctrl.decodeHalt = 1'b1; // unknown opcode
    endcase
  end

endmodule

/* verilog/ctrlIf.sv */
// Decoded control for one instruction, valid only in its own cycle.
`timescale 1ns/1ns

interface ctrlIf;
  import rv32Pkg::*;

  logic     isBranch;
  logic     isJump;
  logic     aluSrcA; // 1 selects pc, 0 rs1
  logic     aluSrcB; // 1 selects imm, 0 rs2
  immSel_t  immSel;
  logic     memRead;
  logic     memWrite;
  memSize_t memSize;
  loadExt_t loadExt;
  logic     regWrite;
  wbSel_t   wbSel;
  logic     decodeHalt;

  modport dec (output isBranch, isJump, aluSrcA, aluSrcB, immSel, memRead, memWrite,
               memSize, loadExt, regWrite, wbSel, decodeHalt);
  modport alu (input aluSrcA, aluSrcB, immSel);
  modport pcu (input isBranch, isJump);
  modport mem (input memRead, memWrite, memSize, loadExt);
  modport wb  (input regWrite, wbSel, decodeHalt);
endinterface

/* verilog/rv32Pkg.sv */
// Instruction word views and the decode select types.
// Field order in each struct follows the RV32I encoding, msb first.
`include "rv32_macros.svh"

package rv32Pkg;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`REGADDR_W-1:0] rs2;
    logic [`REGADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`REGADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } rFmt_t;

  typedef struct packed {
    logic [11:0]           imm11_0;
    logic [`REGADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`REGADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } iFmt_t;

  typedef struct packed {
    logic [6:0]            imm11_5;
    logic [`REGADDR_W-1:0] rs2;
    logic [`REGADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm4_0;
    logic [6:0]            opcode;
  } sFmt_t;

  typedef struct packed {
    logic                  imm12;
    logic [5:0]            imm10_5;
    logic [`REGADDR_W-1:0] rs2;
    logic [`REGADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm4_1;
    logic                  imm11;
    logic [6:0]            opcode;
  } bFmt_t;

  typedef struct packed {
    logic [19:0]           imm31_12;
    logic [`REGADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } uFmt_t;

  typedef struct packed {
    logic                  imm20;
    logic [9:0]            imm10_1;
    logic                  imm11;
    logic [7:0]            imm19_12;
    logic [`REGADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } jFmt_t;

  // one instruction word, six ways to read it
  typedef union packed {
    rFmt_t rFmt;
    iFmt_t iFmt;
    sFmt_t sFmt;
    bFmt_t bFmt;
    uFmt_t uFmt;
    jFmt_t jFmt;
  } instWord_t;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
  } immSel_t;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wbSel_t;

  typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} memSize_t;

  typedef enum logic {LOAD_SIGNED, LOAD_UNSIGNED} loadExt_t;

endpackage

/* verilog/rv32_macros.svh */
// RV32I widths, data memory depth and the fixed opcode/funct codes.
// Only the nine base opcodes are known. Anything else halts the stage.
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

`define XLEN       32
`define REGADDR_W  5

// data memory is word organised, byte addressed
`define MEM_WORDS  64
`define MEM_AW     6

`define OPC_OP     7'b0110011 // register compute
`define OPC_OPIMM  7'b0010011 // immediate compute
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111

`define FUNCT7_ALT 7'b0100000 // sub and sra

`endif
